// File: lsab_defines.svh
`ifndef LSAB_DEFINES_SVH
`define LSAB_DEFINES_SVH

// queue bank geometry
`define LSAB_QUEUES 4
`define LSAB_QID_W 2

// per-queue pointer and length, full at all ones
`define LSAB_DEPTH_W 6

// queue id on top of the pointer
`define LSAB_RAM_AW 8

`define LSAB_DATA_W 32

// one slot always spare, three marks pending at most
`define LSAB_MARK_SLOTS 4
`define LSAB_MARK_PTR_W 2

`endif

// File: lsab_pkg.sv
`include "lsab_defines.svh"

package lsab_pkg;

  typedef logic [`LSAB_QID_W-1:0] qid_t;
  typedef logic [`LSAB_DEPTH_W-1:0] qptr_t;
  typedef logic [`LSAB_RAM_AW-1:0] ram_addr_t;
  typedef logic [`LSAB_DATA_W-1:0] word_t;

  // flags seen by the caller for one queue
  typedef struct packed {
    logic empty;
    logic stop;
  } queue_status_t;

  typedef struct packed {
    logic      en;
    ram_addr_t addr;
    word_t     data;
  } ram_wr_t;

  typedef struct packed {
    logic      en;
    ram_addr_t addr;
  } ram_rd_t;

endpackage

// File: lsab_port_select.sv
`include "lsab_defines.svh"

module lsab_port_select (
  input  logic                                  read,
  input  logic                                  write,
  input  lsab_pkg::qid_t                        read_q,
  input  lsab_pkg::qid_t                        write_q,
  input  lsab_pkg::word_t [`LSAB_QUEUES-1:0]    in_word,
  input  logic [`LSAB_QUEUES-1:0]               do_write,
  input  logic [`LSAB_QUEUES-1:0]               do_read,
  input  lsab_pkg::qptr_t [`LSAB_QUEUES-1:0]    wr_ptr,
  input  lsab_pkg::qptr_t [`LSAB_QUEUES-1:0]    rd_ptr,
  output logic [`LSAB_QUEUES-1:0]               write_req,
  output logic [`LSAB_QUEUES-1:0]               read_req,
  output lsab_pkg::ram_wr_t                     ram_wr,
  output lsab_pkg::ram_rd_t                     ram_rd
);

  import lsab_pkg::*;

  // strobe decode, one request per queue
  always_comb begin
    for (int i = 0; i < `LSAB_QUEUES; i++) begin
      write_req[i] = write && (write_q == qid_t'(i));
      read_req[i]  = read && (read_q == qid_t'(i));
    end
  end

  // write port follows the selected queue
  always_comb begin
    ram_wr.en   = do_write[write_q]; // already gated by full
    ram_wr.addr = {write_q, wr_ptr[write_q]};
    ram_wr.data = in_word[write_q];
  end

  // read port, gated by stop in the queue controller
  always_comb begin
    ram_rd.en   = do_read[read_q];
    ram_rd.addr = {read_q, rd_ptr[read_q]};
  end

endmodule

// File: lsab_queue_ctrl.sv
`include "lsab_defines.svh"

module lsab_queue_ctrl (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    write_req,
  input  logic                    read_req,
  input  logic                    mark_hit,
  output logic                    do_write,
  output logic                    do_read,
  output lsab_pkg::qptr_t         wr_ptr,
  output lsab_pkg::qptr_t         rd_ptr,
  output lsab_pkg::queue_status_t status
);

  import lsab_pkg::*;

  localparam qptr_t LEN_FULL = '1; // 63 words

  qptr_t len;
  qptr_t len_nxt;
  logic  full;
  logic  full_nxt;
  logic  empty_nxt;

  assign do_write = write_req && !full;
  assign do_read  = read_req && !status.stop;

  // flags only move at the boundaries, otherwise they hold
  always_comb begin
    len_nxt   = len;
    full_nxt  = full;
    empty_nxt = status.empty;
    case ({do_read, do_write})
      2'b10: begin
        len_nxt  = len - 1'b1;
        full_nxt = 1'b0;
        if (len == qptr_t'(1)) begin
          empty_nxt = 1'b1; // last word leaves
        end
      end
      2'b01: begin
        len_nxt   = len + 1'b1;
        empty_nxt = 1'b0;
        if (len == LEN_FULL - 1'b1) begin
          full_nxt = 1'b1;
        end
      end
      default: begin
        len_nxt = len; // idle or read and write together
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      len          <= '0;
      full         <= 1'b0;
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      status.empty <= 1'b1;
      status.stop  <= 1'b1;
    end else begin
      len          <= len_nxt;
      full         <= full_nxt;
      status.empty <= empty_nxt;
      // a mark hit holds reads off for one cycle
      status.stop  <= empty_nxt || mark_hit;
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// File: lsab_mark_queue.sv
`include "lsab_defines.svh"

module lsab_mark_queue (
  input  logic            CLK,
  input  logic            RST,
  input  logic            do_write,
  input  logic            do_read,
  input  logic            int_in,
  input  logic            careof_int,
  input  lsab_pkg::qptr_t wr_ptr,
  input  lsab_pkg::qptr_t rd_ptr,
  output logic            mark_hit
);

  import lsab_pkg::*;

  typedef logic [`LSAB_MARK_PTR_W-1:0] mptr_t;

  qptr_t marks [`LSAB_MARK_SLOTS]; // queue positions of marked words
  mptr_t head;   // oldest pending mark
  mptr_t trail;  // always one behind head
  mptr_t tail;   // next free slot
  logic  buf_empty;
  logic  buf_full;
  logic  hit;

  assign buf_empty = head == tail;
  assign buf_full  = trail == tail;

  // the word being read is the oldest marked one
  assign hit      = do_read && !buf_empty && (marks[head] == rd_ptr);
  assign mark_hit = hit && careof_int;

  always_ff @(posedge CLK) begin
    if (!RST) begin
      head  <= mptr_t'(1);
      trail <= '0;
      tail  <= mptr_t'(1);
    end else begin
      if (hit) begin
        head  <= head + 1'b1; // consumed even if nobody cares
        trail <= trail + 1'b1;
      end
      if (int_in && do_write && !buf_full) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // marks beyond three are dropped, the word itself still goes in
  always_ff @(posedge CLK) begin
    if (int_in && do_write && !buf_full) begin
      marks[tail] <= wr_ptr;
    end
  end

endmodule

// File: lsab_ram.sv
`include "lsab_defines.svh"

module lsab_ram (
  input  logic              CLK,
  input  logic              RST,
  input  lsab_pkg::ram_wr_t ram_wr,
  input  lsab_pkg::ram_rd_t ram_rd,
  output lsab_pkg::word_t   out_word
);

  import lsab_pkg::*;

  word_t mem [2**`LSAB_RAM_AW];
  word_t rd_data;
  logic  rd_en_d;

  always_ff @(posedge CLK) begin
    if (ram_wr.en) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
    if (ram_rd.en) begin
      rd_data <= mem[ram_rd.addr]; // first edge of the read
    end
  end

  // holding register loads one edge later
  always_ff @(posedge CLK) begin
    if (!RST) begin
      rd_en_d  <= 1'b0;
      out_word <= '0;
    end else begin
      rd_en_d <= ram_rd.en;
      if (rd_en_d) begin
        out_word <= rd_data;
      end
    end
  end

endmodule

// File: lsab_top.sv
`include "lsab_defines.svh"

module lsab_top (
  input  logic                                     CLK,
  input  logic                                     RST,
  input  logic                                     read,
  input  logic                                     write,
  input  lsab_pkg::qid_t                           read_q,
  input  lsab_pkg::qid_t                           write_q,
  input  lsab_pkg::word_t [`LSAB_QUEUES-1:0]       in_word,
  input  logic [`LSAB_QUEUES-1:0]                  int_in,
  input  logic [`LSAB_QUEUES-1:0]                  careof_int,
  output lsab_pkg::word_t                          out_word,
  output lsab_pkg::queue_status_t [`LSAB_QUEUES-1:0] status
);

  import lsab_pkg::*;

  logic [`LSAB_QUEUES-1:0]  write_req;
  logic [`LSAB_QUEUES-1:0]  read_req;
  logic [`LSAB_QUEUES-1:0]  do_write;
  logic [`LSAB_QUEUES-1:0]  do_read;
  logic [`LSAB_QUEUES-1:0]  mark_hit;
  qptr_t [`LSAB_QUEUES-1:0] wr_ptr;
  qptr_t [`LSAB_QUEUES-1:0] rd_ptr;
  ram_wr_t                  ram_wr;
  ram_rd_t                  ram_rd;

  lsab_port_select u_port_select (
    .read      (read),
    .write     (write),
    .read_q    (read_q),
    .write_q   (write_q),
    .in_word   (in_word),
    .do_write  (do_write),
    .do_read   (do_read),
    .wr_ptr    (wr_ptr),
    .rd_ptr    (rd_ptr),
    .write_req (write_req),
    .read_req  (read_req),
    .ram_wr    (ram_wr),
    .ram_rd    (ram_rd)
  );

  // one controller and one mark buffer per queue
  for (genvar i = 0; i < `LSAB_QUEUES; i++) begin : g_queue
    lsab_queue_ctrl u_ctrl (
      .CLK       (CLK),
      .RST       (RST),
      .write_req (write_req[i]),
      .read_req  (read_req[i]),
      .mark_hit  (mark_hit[i]),
      .do_write  (do_write[i]),
      .do_read   (do_read[i]),
      .wr_ptr    (wr_ptr[i]),
      .rd_ptr    (rd_ptr[i]),
      .status    (status[i])
    );

    lsab_mark_queue u_marks (
      .CLK        (CLK),
      .RST        (RST),
      .do_write   (do_write[i]),
      .do_read    (do_read[i]),
      .int_in     (int_in[i]),
      .careof_int (careof_int[i]),
      .wr_ptr     (wr_ptr[i]),
      .rd_ptr     (rd_ptr[i]),
      .mark_hit   (mark_hit[i])
    );
  end

  lsab_ram u_ram (
    .CLK      (CLK),
    .RST      (RST),
    .ram_wr   (ram_wr),
    .ram_rd   (ram_rd),
    .out_word (out_word)
  );

endmodule

// File: lsab_checker.sv
`include "lsab_defines.svh"

module lsab_checker (
  input  logic                                      CLK,
  input  logic                                      RST,
  input  logic [`LSAB_QUEUES-1:0]                   do_read,
  input  logic [`LSAB_QUEUES-1:0]                   mark_hit,
  input  lsab_pkg::word_t                           out_word,
  input  lsab_pkg::queue_status_t [`LSAB_QUEUES-1:0] status
);

  timeunit 1ns;
  timeprecision 1ps;

  import lsab_pkg::*;

  int fail_count = 0;

  // holding register only moves two edges after an accepted read
  a_out_hold: assert property (@(posedge CLK) disable iff (!RST)
      RST && $past(RST) && !$past(|do_read, 2) |-> $stable(out_word))
    else begin
      fail_count++;
      $error("out_word changed without an accepted read two cycles earlier");
    end

  for (genvar i = 0; i < `LSAB_QUEUES; i++) begin : g_queue
    a_stop_covers_empty: assert property (@(posedge CLK) disable iff (!RST)
        status[i].empty |-> status[i].stop)
      else begin
        fail_count++;
        $error("queue %0d is empty but stop is low", i);
      end

    // one cycle only while words remain
    a_hit_stop_falls: assert property (@(posedge CLK) disable iff (!RST)
        mark_hit[i] ##1 !status[i].empty |=> !status[i].stop)
      else begin
        fail_count++;
        $error("queue %0d stop stayed high after a mark hit", i);
      end
  end

endmodule

// File: tb_lsab.sv
`include "lsab_defines.svh"

module tb_lsab;

  timeunit 1ns;
  timeprecision 1ps;

  import lsab_pkg::*;

  localparam int SLOTS = 2**`LSAB_DEPTH_W;
  localparam int QFULL = SLOTS - 1;
  localparam int MARKS = `LSAB_MARK_SLOTS - 1;
  localparam int SETTLE_LIMIT = 8;

  logic                                CLK;
  logic                                RST;
  logic                                read;
  logic                                write;
  qid_t                                read_q;
  qid_t                                write_q;
  word_t [`LSAB_QUEUES-1:0]            in_word;
  logic [`LSAB_QUEUES-1:0]             int_in;
  logic [`LSAB_QUEUES-1:0]             careof_int;
  word_t                               out_word;
  queue_status_t [`LSAB_QUEUES-1:0]    status;

  // reference model state
  word_t mem_m [`LSAB_QUEUES][SLOTS];
  bit    mark_m [`LSAB_QUEUES][SLOTS]; // word holds a recorded mark
  int    head [`LSAB_QUEUES];
  int    cnt [`LSAB_QUEUES];
  int    pend [`LSAB_QUEUES];        // marks waiting in the buffer
  bit    m_empty [`LSAB_QUEUES];
  bit    m_stop [`LSAB_QUEUES];
  word_t out_m;
  word_t pend_w;
  bit    pend_v;
  bit    pend_fv;
  word_t pend_fw;
  bit    out_fv;
  word_t out_fw;
  bit    last_acc;
  bit    aborted = 1'b0;
  int    errors = 0;
  int    checks = 0;
  logic [31:0] lfsr = 32'h62d8cc2e;

  lsab_top UUT (
    .CLK        (CLK),
    .RST        (RST),
    .read       (read),
    .write      (write),
    .read_q     (read_q),
    .write_q    (write_q),
    .in_word    (in_word),
    .int_in     (int_in),
    .careof_int (careof_int),
    .out_word   (out_word),
    .status     (status)
  );

  bind lsab_top lsab_checker u_checker (
    .CLK      (CLK),
    .RST      (RST),
    .do_read  (do_read),
    .mark_hit (mark_hit),
    .out_word (out_word),
    .status   (status)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1
    end
    return s >> 1;
  endfunction

  task automatic next_random(output word_t w);
    w = '0;
    for (int i = 0; i < `LSAB_DATA_W; i++) begin
      w    = {w[`LSAB_DATA_W-2:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic model_reset();
    for (int q = 0; q < `LSAB_QUEUES; q++) begin
      head[q]    = 0;
      cnt[q]     = 0;
      pend[q]    = 0;
      m_empty[q] = 1'b1;
      m_stop[q]  = 1'b1;
    end
    out_m   = '0;
    pend_v  = 1'b0;
    pend_fv = 1'b0;
    out_fv  = 1'b0;
  endtask

  // state after the next rising edge under this cycle's inputs
  task automatic model_edge(input bit rd, input int rq, input bit careof, input bit wr,
                            input int wq, input word_t data, input bit intf,
                            input bit fchk, input word_t fword);
    bit acc_r;
    bit acc_w;
    bit hit;
    int slot;
    acc_r = rd && !m_stop[rq];
    acc_w = wr && (cnt[wq] < QFULL);
    hit   = 1'b0;
    if (pend_v) begin
      out_m = pend_w; // holding register loads on the second edge
    end
    out_fv  = pend_fv;
    out_fw  = pend_fw;
    pend_v  = acc_r;
    pend_fv = fchk;
    pend_fw = fword;
    if (acc_w) begin
      slot             = (head[wq] + cnt[wq]) % SLOTS;
      mem_m[wq][slot]  = data;
      mark_m[wq][slot] = intf && (pend[wq] < MARKS); // extra marks dropped
      if (mark_m[wq][slot]) begin
        pend[wq]++;
      end
      cnt[wq]++;
    end
    if (acc_r) begin
      pend_w = mem_m[rq][head[rq]];
      hit    = mark_m[rq][head[rq]];
      if (hit) begin
        pend[rq]--;
      end
      head[rq] = (head[rq] + 1) % SLOTS;
      cnt[rq]--;
    end
    for (int q = 0; q < `LSAB_QUEUES; q++) begin
      m_empty[q] = cnt[q] == 0;
      m_stop[q]  = m_empty[q] || (hit && careof && q == rq);
    end
    last_acc = acc_r;
  endtask

  task automatic compare_outputs();
    for (int q = 0; q < `LSAB_QUEUES; q++) begin
      check_bit($sformatf("status[%0d].empty", q), status[q].empty, m_empty[q]);
      check_bit($sformatf("status[%0d].stop", q), status[q].stop, m_stop[q]);
    end
    check_word("out_word", out_word, out_m);
    if (out_fv) begin
      check_word("out_word", out_word, out_fw); // value given in the stimulus file
    end
  endtask

  task automatic drive_cycle(input bit rd, input int rq, input bit careof, input bit wr,
                             input int wq, input word_t data, input bit intf,
                             input bit fchk, input word_t fword);
    logic [`LSAB_QUEUES-1:0] care_v;
    logic [`LSAB_QUEUES-1:0] int_v;
    care_v     = '0;
    int_v      = '0;
    care_v[rq] = rd && careof;
    int_v[wq]  = wr && intf;
    @(posedge CLK);
    read        <= rd;
    read_q      <= qid_t'(rq);
    write       <= wr;
    write_q     <= qid_t'(wq);
    in_word[wq] <= data;
    int_in      <= int_v;
    careof_int  <= care_v;
    @(negedge CLK);
    compare_outputs();
    model_edge(rd, rq, careof, wr, wq, data, intf, fchk, fword);
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 0, 1'b0, 1'b0, 0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    RST        <= 1'b0;
    read       <= 1'b0;
    write      <= 1'b0;
    int_in     <= '0;
    careof_int <= '0;
    repeat (2) @(posedge CLK);
    RST <= 1'b1;
    model_reset();
    @(negedge CLK);
    for (int q = 0; q < `LSAB_QUEUES; q++) begin
      check_bit($sformatf("status[%0d].empty", q), status[q].empty, 1'b1);
      check_bit($sformatf("status[%0d].stop", q), status[q].stop, 1'b1);
    end
    check_word("out_word", out_word, '0);
    model_edge(1'b0, 0, 1'b0, 1'b0, 0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic settle();
    int guard;
    guard = 0;
    idle_cycle();
    while ((pend_v || pend_fv || out_fv) && guard < SETTLE_LIMIT) begin
      idle_cycle();
      guard++;
    end
    if (pend_v || pend_fv || out_fv) begin
      aborted = 1'b1;
      $display("read pipeline still busy after %0d idle cycles", SETTLE_LIMIT);
    end
  endtask

  task automatic fill_queue(input int q, input int n);
    word_t w;
    for (int i = 0; i < n; i++) begin
      next_random(w);
      drive_cycle(1'b0, 0, 1'b0, 1'b1, q, w, 1'b0, 1'b0, '0);
    end
  endtask

  // back-to-back reads until n are accepted
  task automatic drain_queue(input int q, input int n, input bit careof);
    int got;
    int guard;
    got   = 0;
    guard = 0;
    while (got < n && guard < 4 * n + 16) begin
      drive_cycle(1'b1, q, careof, 1'b0, 0, '0, 1'b0, 1'b0, '0);
      if (last_acc) begin
        got++;
      end
      guard++;
    end
    if (got < n) begin
      aborted = 1'b1;
      $display("queue %0d gave only %0d of %0d words before the read loop gave up", q, got, n);
    end
  endtask

  task automatic malformed(input string line);
    errors++;
    $display("stimulus line could not be parsed: %s", line);
  endtask

  initial begin : stimulus
    int    fd;
    int    q;
    int    n;
    int    f1;
    int    f2;
    int    total;
    word_t data;
    string line;
    string cmd;
    RST        = 1'b0;
    read       = 1'b0;
    write      = 1'b0;
    read_q     = '0;
    write_q    = '0;
    in_word    = '0;
    int_in     = '0;
    careof_int = '0;
    model_reset();
    fd = $fopen("lsab_stim.txt", "r");
    if (fd == 0) begin
      aborted = 1'b1;
      $display("stimulus file lsab_stim.txt could not be opened");
    end
    while (fd != 0 && !aborted && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if ($sscanf(line, "%s", cmd) != 1 || cmd.getc(0) == "#") begin
        continue; // blank or comment
      end
      if (cmd == "reset") begin
        apply_reset();
      end else if (cmd == "write") begin
        if ($sscanf(line, "%s %d %h %d", cmd, q, data, f1) != 4) begin
          malformed(line);
        end else begin
          drive_cycle(1'b0, 0, 1'b0, 1'b1, q, data, f1[0], 1'b0, '0);
        end
      end else if (cmd == "fill") begin
        if ($sscanf(line, "%s %d %d", cmd, q, n) != 3) begin
          malformed(line);
        end else begin
          fill_queue(q, n);
        end
      end else if (cmd == "read") begin
        if ($sscanf(line, "%s %d %d %h", cmd, q, f1, data) != 4) begin
          malformed(line);
        end else begin
          drive_cycle(1'b1, q, f1[0], 1'b0, 0, '0, 1'b0, 1'b1, data);
        end
      end else if (cmd == "drain") begin
        if ($sscanf(line, "%s %d %d %d", cmd, q, n, f1) != 4) begin
          malformed(line);
        end else begin
          drain_queue(q, n, f1[0]);
        end
      end else if (cmd == "status") begin
        if ($sscanf(line, "%s %d %d %d", cmd, q, f1, f2) != 4) begin
          malformed(line);
        end else begin
          settle();
          check_bit($sformatf("status[%0d].empty", q), status[q].empty, f1[0]);
          check_bit($sformatf("status[%0d].stop", q), status[q].stop, f2[0]);
        end
      end else begin
        malformed(line);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (!aborted) begin
      settle();
    end
    total = errors + UUT.u_checker.fail_count;
    $display("checks: %0d  errors: %0d  assertion failures: %0d",
             checks, errors, UUT.u_checker.fail_count);
    if (total == 0 && !aborted) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: lsab_stim.txt
# columns: command queue then fields, data in hex, counts and flags in decimal
# reset | write q data int | fill q count | read q careof expected | drain q count careof | status q empty stop
reset
status 0 1 1
# interleaved writes, pipelined reads per queue
write 0 a0000001 0
write 1 b0000001 0
write 0 a0000002 0
write 1 b0000002 0
write 0 a0000003 0
status 0 0 0
read 1 0 b0000001
read 0 0 a0000001
read 0 0 a0000002
read 1 0 b0000002
read 0 0 a0000003
status 0 1 1
status 1 1 1
# read on an empty queue is ignored
read 2 0 a0000003
write 2 c0000001 0
read 2 0 c0000001
# 64 writes keep 63 words
fill 0 64
status 0 0 0
drain 0 63 0
status 0 1 1
# marked word stops for one cycle, the next read is ignored
write 1 d0000001 1
write 1 d0000002 0
write 1 d0000003 0
read 1 1 d0000001
read 1 1 d0000001
read 1 1 d0000002
status 1 0 0
drain 1 1 1
status 1 1 1
# mark consumed without stop when careof is low
write 3 e0000001 1
write 3 e0000002 0
read 3 0 e0000001
read 3 0 e0000002
status 3 1 1
# four marks pending, only three stop
write 2 f0000001 1
write 2 f0000002 1
write 2 f0000003 1
write 2 f0000004 1
write 2 f0000005 0
read 2 1 f0000001
read 2 1 f0000001
read 2 1 f0000002
read 2 1 f0000002
read 2 1 f0000003
read 2 1 f0000003
read 2 1 f0000004
read 2 1 f0000005
status 2 1 1

// File: verilog.f
+incdir+.
lsab_pkg.sv
lsab_port_select.sv
lsab_queue_ctrl.sv
lsab_mark_queue.sv
lsab_ram.sv
lsab_top.sv
lsab_checker.sv
tb_lsab.sv
